// ==== all.f ====
+incdir+bench
hw/muscle_pkg.sv
hw/spike_activation.sv
hw/length_weight.sv
hw/tension_integrator.sv
hw/muscle_top.sv
bench/muscle_tb.sv

// ==== bench/muscle_ref.svh ====
`ifndef MUSCLE_REF_SVH
`define MUSCLE_REF_SVH

// signed word limits of the datapath
localparam longint WORD_MAX = (longint'(1) <<< (DATA_W - 1)) - 1;
localparam longint WORD_MIN = -WORD_MAX - 1;

// raw fixed point constants, filled in by clear_model_state
longint cf_b1;
longint cf_b2;
longint cf_a1;
longint cf_a2;
longint cf_len;
longint cf_vel;
longint cf_ten;
longint cf_act;
longint cf_rest;
longint cf_lo;
longint cf_mid;
longint cf_hi;
longint cf_m4;
longint cf_8;
longint cf_3;
longint cf_2;

// two-deep histories and the integrated tension
longint hist_s1;
longint hist_s2;
longint hist_h1;
longint hist_h2;
longint model_t;

//////////////////////
// arithmetic rules
// clamp to the signed word range
function automatic longint clamp_word(input longint v);
    if (v > WORD_MAX) begin
        return WORD_MAX;
    end
    if (v < WORD_MIN) begin
        return WORD_MIN;
    end
    return v;
endfunction

// exact product, arithmetic shift floors it, then clamp
function automatic longint mul_floor(input longint a, input longint b);
    return clamp_word((a * b) >>> FRAC_W);
endfunction

function automatic longint add_clamp(input longint a, input longint b);
    return clamp_word(a + b);
endfunction

// round to nearest, halves away from zero
function automatic longint to_fixed(input real r);
    real scaled;
    scaled = r * (2.0 ** FRAC_W);
    if (scaled >= 0.0) begin
        return longint'($floor(scaled + 0.5));
    end
    return -longint'($floor(-scaled + 0.5));
endfunction

//////////////////////
// length weighting
function automatic logic outside_window(input longint x);
    return (x <= cf_lo) || (x > cf_hi);
endfunction

function automatic longint weight_at(input longint x);
    longint x_sq;
    longint w;
    if (outside_window(x)) begin
        return '0;
    end
    x_sq = mul_floor(x, x);
    // rising limb -4x^2 + 8x - 3
    if (x <= cf_mid) begin
        w = add_clamp(mul_floor(cf_m4, x_sq), mul_floor(cf_8, x));
        return add_clamp(w, -cf_3);
    end
    // falling limb -x^2 + 2x
    return add_clamp(mul_floor(x, cf_2), -x_sq);
endfunction

task automatic clear_model_state();
    cf_b1   = to_fixed(H_B1);
    cf_b2   = to_fixed(H_B2);
    cf_a1   = to_fixed(H_A1);
    cf_a2   = to_fixed(H_A2);
    cf_len  = to_fixed(K_LEN);
    cf_vel  = to_fixed(K_VEL);
    cf_ten  = to_fixed(K_TEN);
    cf_act  = to_fixed(K_ACT);
    cf_rest = to_fixed(L_REST);
    cf_lo   = to_fixed(W_ACT_LO);
    cf_mid  = to_fixed(W_ACT_MID);
    cf_hi   = to_fixed(W_ACT_HI);
    cf_m4   = to_fixed(-4.0);
    cf_8    = to_fixed(8.0);
    cf_3    = to_fixed(3.0);
    cf_2    = to_fixed(2.0);
    hist_s1 = 0;
    hist_s2 = 0;
    hist_h1 = 0;
    hist_h2 = 0;
    model_t = 0;
endtask

// one model step, returns drive A and the tension after the update
task automatic predict_step(input logic [DATA_W-1:0] cnt,
                            input logic signed [DATA_W-1:0] len,
                            input logic signed [DATA_W-1:0] vel,
                            output longint drv,
                            output longint frc);
    longint s_new;
    longint sum_b;
    longint sum_a;
    longint h_new;
    longint x;
    longint stretch;
    longint part;
    longint rate;
    // count is unsigned, so the cast zero-extends
    s_new = clamp_word(longint'(cnt) <<< SPIKE_SHIFT);
    sum_b = add_clamp(mul_floor(cf_b1, hist_s1), mul_floor(cf_b2, hist_s2));
    sum_a = add_clamp(mul_floor(cf_a1, hist_h1), mul_floor(cf_a2, hist_h2));
    h_new = add_clamp(sum_b, -sum_a);
    hist_s2 = hist_s1;
    hist_s1 = s_new;
    hist_h2 = hist_h1;
    hist_h1 = h_new;
    x   = longint'(len);
    drv = mul_floor(weight_at(x), h_new);
    // rate terms summed left to right
    stretch = add_clamp(x, -cf_rest);
    part    = add_clamp(mul_floor(cf_len, stretch), mul_floor(cf_vel, longint'(vel)));
    part    = add_clamp(part, -mul_floor(cf_ten, model_t));
    rate    = add_clamp(part, mul_floor(cf_act, drv));
    model_t = add_clamp(model_t, rate >>> DT_SHIFT);
    frc     = model_t;
endtask

`endif

// ==== bench/muscle_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module muscle_tb
    import muscle_pkg::*;
();

    localparam int DATA_W      = DATA_W_DEF;
    localparam int FRAC_W      = FRAC_W_DEF;
    localparam int SPIKE_SHIFT = 10;
    localparam int DT_SHIFT    = 10;
    localparam int CLK_HALF    = 10;
    localparam int SEED        = 32'h2997;

    // steps per test
    localparam int N_B2B    = 20;
    localparam int N_SPARSE = 20;
    localparam int N_WIN    = 30;
    localparam int N_TRAJ   = 300;
    localparam int N_SAT    = 400;
    localparam int TOTAL_STEPS = N_B2B + N_SPARSE + N_WIN + N_TRAJ + N_SAT;
    // 3 cycles per step, sparse gaps, then a margin
    localparam int WATCHDOG_CYCLES = TOTAL_STEPS * 3 + N_SPARSE * 8 + 200;

    // lengths 0.4 .. 2.2, velocities about +-0.05
    localparam int LEN_MIN  = 26214;
    localparam int LEN_SPAN = 117966;
    localparam int VEL_HALF = 3277;

    `include "muscle_ref.svh"

    logic                     clk;
    logic                     reset;
    logic                     step_i;
    logic        [DATA_W-1:0] spike_cnt_i;
    logic signed [DATA_W-1:0] length_i;
    logic signed [DATA_W-1:0] velocity_i;
    logic                     force_valid_o;
    logic signed [DATA_W-1:0] force_o;
    logic signed [DATA_W-1:0] drive_o;

    // expected values of the step being driven
    logic signed [DATA_W-1:0] exp_drive;
    logic signed [DATA_W-1:0] exp_force;
    logic                     exp_outside;

    // expected values follow the pipeline, one slot per cycle
    logic [2:0]               step_d;
    logic [1:0]               outside_d;
    logic signed [DATA_W-1:0] exp_drive_d [0:1];
    logic signed [DATA_W-1:0] exp_force_d [0:2];

    int    steps_sent  = 0;
    int    forces_seen = 0;
    int    err_value   = 0;
    int    err_timing  = 0;
    int    err_reset   = 0;
    int    guard;
    string test_name;

    muscle_top #(
        .DATA_W      (DATA_W),
        .FRAC_W      (FRAC_W),
        .SPIKE_SHIFT (SPIKE_SHIFT),
        .DT_SHIFT    (DT_SHIFT)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .step_i        (step_i),
        .spike_cnt_i   (spike_cnt_i),
        .length_i      (length_i),
        .velocity_i    (velocity_i),
        .force_valid_o (force_valid_o),
        .force_o       (force_o),
        .drive_o       (drive_o)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            step_d    <= '0;
            outside_d <= '0;
        end else begin
            step_d    <= {step_d[1:0], step_i};
            outside_d <= {outside_d[0], exp_outside};
        end
    end

    always @(posedge clk) begin
        exp_drive_d[0] <= exp_drive;
        exp_drive_d[1] <= exp_drive_d[0];
        exp_force_d[0] <= exp_force;
        exp_force_d[1] <= exp_force_d[0];
        exp_force_d[2] <= exp_force_d[1];
    end

    always @(negedge clk) begin
        if (!reset && force_valid_o) begin
            forces_seen <= forces_seen + 1;
        end
    end

    //////////////////////
    // checks
    // sampled on the falling edge, where every DUT output is settled
    a_reset_clear: assert property (
        @(negedge clk) reset |-> (!force_valid_o && force_o == '0 && drive_o == '0)
    ) else begin
        err_reset++;
        $display("ERR %s valid/force/drive expected 0/0/0 actual %0b/%0d/%0d",
                 test_name, force_valid_o, force_o, drive_o);
    end

    // before any step the outputs stay at their reset values
    a_idle_clear: assert property (
        @(negedge clk) disable iff (reset)
        (steps_sent == 0) |-> (!force_valid_o && force_o == '0 && drive_o == '0)
    ) else begin
        err_reset++;
        $display("ERR %s idle force expected 0 actual %0d", test_name, force_o);
    end

    a_latency: assert property (
        @(negedge clk) disable iff (reset) force_valid_o == step_d[2]
    ) else begin
        err_timing++;
        $display("ERR %s force_valid expected %0b actual %0b",
                 test_name, step_d[2], force_valid_o);
    end

    // drive is registered one cycle before the force update
    a_drive_value: assert property (
        @(negedge clk) disable iff (reset) step_d[1] |-> (drive_o == exp_drive_d[1])
    ) else begin
        err_value++;
        $display("ERR %s drive expected %0d actual %0d", test_name, exp_drive_d[1], drive_o);
    end

    a_drive_window: assert property (
        @(negedge clk) disable iff (reset) (step_d[1] && outside_d[1]) |-> (drive_o == '0)
    ) else begin
        err_value++;
        $display("ERR %s drive outside window expected 0 actual %0d", test_name, drive_o);
    end

    a_force_value: assert property (
        @(negedge clk) disable iff (reset) step_d[2] |-> (force_o == exp_force_d[2])
    ) else begin
        err_value++;
        $display("ERR %s force expected %0d actual %0d", test_name, exp_force_d[2], force_o);
    end

    //////////////////////
    // stimulus helpers
    function automatic logic [DATA_W-1:0] pick_spike();
        return DATA_W'($urandom % 32'd16);
    endfunction

    function automatic logic signed [DATA_W-1:0] draw_length();
        return DATA_W'(LEN_MIN + int'($urandom % LEN_SPAN));
    endfunction

    function automatic logic signed [DATA_W-1:0] small_velocity();
        return DATA_W'(int'($urandom % (2 * VEL_HALF + 1)) - VEL_HALF);
    endfunction

    // lengths on and next to 0.5, 1.0, 2.0 and one at 2.5
    function automatic logic signed [DATA_W-1:0] breakpoint_length(input int idx);
        case (idx)
            0:       return DATA_W'(32767);
            1:       return DATA_W'(32768);
            2:       return DATA_W'(32769);
            3:       return DATA_W'(65535);
            4:       return DATA_W'(65536);
            5:       return DATA_W'(65537);
            6:       return DATA_W'(131071);
            7:       return DATA_W'(131072);
            8:       return DATA_W'(131073);
            default: return DATA_W'(163840);
        endcase
    endfunction

    // one strobe with its inputs, the model runs at the same time
    task automatic send_step(input logic [DATA_W-1:0] cnt,
                             input logic signed [DATA_W-1:0] len,
                             input logic signed [DATA_W-1:0] vel);
        longint drv;
        longint frc;
        @(posedge clk);
        #2;
        step_i      = 1'b1;
        spike_cnt_i = cnt;
        length_i    = len;
        velocity_i  = vel;
        predict_step(cnt, len, vel, drv, frc);
        exp_drive   = DATA_W'(drv);
        exp_force   = DATA_W'(frc);
        exp_outside = outside_window(longint'(len));
        steps_sent++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            step_i = 1'b0;
        end
    endtask

    //////////////////////
    // test sequence
    initial begin
        clk         = 1'b0;
        reset       = 1'b0;
        step_i      = 1'b0;
        spike_cnt_i = '0;
        length_i    = '0;
        velocity_i  = '0;
        exp_drive   = '0;
        exp_force   = '0;
        exp_outside = 1'b0;
        void'($urandom(SEED));
        clear_model_state();
        test_name = "reset";
        #1;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        idle_cycles(3);

        test_name = "latency";
        for (int i = 0; i < N_B2B; i++) begin
            send_step(pick_spike(), draw_length(), small_velocity());
        end
        idle_cycles(4);
        for (int i = 0; i < N_SPARSE; i++) begin
            send_step(pick_spike(), draw_length(), small_velocity());
            idle_cycles(1 + int'($urandom % 5));
        end
        idle_cycles(4);

        test_name = "length_window";
        for (int i = 0; i < N_WIN; i++) begin
            send_step(pick_spike(), breakpoint_length(i % 10), small_velocity());
        end
        idle_cycles(4);

        // mostly back to back, now and then a gap
        test_name = "trajectory";
        for (int i = 0; i < N_TRAJ; i++) begin
            send_step(pick_spike(), draw_length(), small_velocity());
            if (($urandom % 4) == 0) begin
                idle_cycles(1);
            end
        end
        idle_cycles(4);

        // full count and top velocity at resting length
        test_name = "saturation";
        for (int i = 0; i < N_SAT; i++) begin
            send_step('1, DATA_W'(65536), DATA_W'(WORD_MAX));
        end
        idle_cycles(1);

        // drain the pipeline
        guard = 0;
        while (forces_seen < steps_sent && guard < 16) begin
            @(posedge clk);
            guard++;
        end
        a_all_forces: assert (forces_seen == steps_sent) else begin
            err_timing++;
            $display("%0d steps were sent but %0d force strobes came back",
                     steps_sent, forces_seen);
        end

        $display("errors: value %0d, timing %0d, reset %0d", err_value, err_timing, err_reset);
        if (err_value + err_timing + err_reset == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("watchdog expired before the test sequence finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/length_weight.sv ====
`timescale 1ns/1ps
`default_nettype none

module length_weight import muscle_pkg::*; #(
    parameter int DATA_W = DATA_W_DEF,
    parameter int FRAC_W = FRAC_W_DEF
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     act_valid_i,
    input  logic signed [DATA_W-1:0] act_i,
    input  logic signed [DATA_W-1:0] length_i,
    input  logic signed [DATA_W-1:0] velocity_i,
    output logic                     drive_valid_o,
    output logic signed [DATA_W-1:0] drive_o,
    output logic signed [DATA_W-1:0] length_o,
    output logic signed [DATA_W-1:0] velocity_o
);

    // breakpoints and polynomial constants
    localparam fx_wide_t C_LO    = fx_const(W_ACT_LO, FRAC_W);
    localparam fx_wide_t C_MID   = fx_const(W_ACT_MID, FRAC_W);
    localparam fx_wide_t C_HI    = fx_const(W_ACT_HI, FRAC_W);
    localparam fx_wide_t C_M4    = fx_const(-4.0, FRAC_W);
    localparam fx_wide_t C_8     = fx_const(8.0, FRAC_W);
    localparam fx_wide_t C_3     = fx_const(3.0, FRAC_W);
    localparam fx_wide_t C_2     = fx_const(2.0, FRAC_W);

    fx_wide_t x_w;
    fx_wide_t x_sq;
    fx_wide_t w_rise;
    fx_wide_t w_fall;
    fx_wide_t weight;
    logic signed [DATA_W-1:0] drive_next;

    //////////////////////
    // weight curve
    always_comb begin
        x_w    = fx_wide_t'(length_i);
        x_sq   = fx_mul(x_w, x_w, DATA_W, FRAC_W);
        // rising part -4x^2 + 8x - 3
        w_rise = fx_add(fx_mul(C_M4, x_sq, DATA_W, FRAC_W),
                        fx_mul(C_8, x_w, DATA_W, FRAC_W), DATA_W);
        w_rise = fx_add(w_rise, -C_3, DATA_W);
        // falling part -x^2 + 2x
        w_fall = fx_add(fx_mul(x_w, C_2, DATA_W, FRAC_W), -x_sq, DATA_W);
        if (x_w <= C_LO) begin
            weight = '0;
        end else if (x_w <= C_MID) begin
            weight = w_rise;
        end else if (x_w <= C_HI) begin
            weight = w_fall;
        end else begin
            weight = '0;
        end
        // active drive A = weight * activation
        drive_next = DATA_W'(fx_mul(weight, fx_wide_t'(act_i), DATA_W, FRAC_W));
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            drive_valid_o <= 1'b0;
            drive_o       <= '0;
        end else begin
            drive_valid_o <= act_valid_i;
            if (act_valid_i) begin
                drive_o <= drive_next;
            end
        end
    end

    // length and velocity ride along with A into the next stage
    always_ff @(posedge clk) begin
        if (act_valid_i) begin
            length_o   <= length_i;
            velocity_o <= velocity_i;
        end
    end

    // floor rounding of x^2 keeps both limbs within [0, 1]
    a_weight_in_range: assert property (
        @(posedge clk) disable iff (reset)
        act_valid_i |-> (weight >= 0 && weight <= C_MID)
    );

endmodule

`default_nettype wire

// ==== hw/muscle_pkg.sv ====
`default_nettype none

package muscle_pkg;

    // default word layout, signed Q15.16
    localparam int DATA_W_DEF = 32;
    localparam int FRAC_W_DEF = 16;

    // wide enough for any product of two words up to 64 bits
    localparam int FX_WIDE_W = 128;
    typedef logic signed [FX_WIDE_W-1:0] fx_wide_t;

    //////////////////////
    // model coefficients
    // h(x) difference equation, Shadmehr active state
    localparam real H_B1 = 2.185;
    localparam real H_B2 = -2.176;
    localparam real H_A1 = -1.942;
    localparam real H_A2 = 0.943;

    // tension rate terms: Kse*Kpe/b, Kse, Kse/b*(1+Kpe/Kse), Kse/b
    localparam real K_LEN = 204.0;
    localparam real K_VEL = 136.0;
    localparam real K_TEN = 4.22;
    localparam real K_ACT = 2.72;

    // length breakpoints of the weight curve
    localparam real W_ACT_LO  = 0.5;
    localparam real W_ACT_MID = 1.0;
    localparam real W_ACT_HI  = 2.0;
    localparam real L_REST    = 1.0;

    //////////////////////
    // fixed point helpers
    // nearest fw-bit value, elaboration only
    function automatic fx_wide_t fx_const(real r, int fw);
        return fx_wide_t'(longint'(r * (2.0 ** fw)));
    endfunction

    // clamp to the signed dw-bit range
    function automatic fx_wide_t fx_sat(fx_wide_t v, int dw);
        fx_wide_t hi;
        fx_wide_t lo;
        hi = (fx_wide_t'(1) <<< (dw - 1)) - fx_wide_t'(1);
        lo = -hi - fx_wide_t'(1);
        if (v > hi) begin
            return hi;
        end
        if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    // exact product, floor by the fraction bits, then clamp
    function automatic fx_wide_t fx_mul(fx_wide_t a, fx_wide_t b, int dw, int fw);
        fx_wide_t p;
        p = a * b;
        return fx_sat(p >>> fw, dw);
    endfunction

    // saturating sum, subtract by passing a negated operand
    function automatic fx_wide_t fx_add(fx_wide_t a, fx_wide_t b, int dw);
        return fx_sat(a + b, dw);
    endfunction

endpackage

`default_nettype wire

// ==== hw/muscle_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module muscle_top import muscle_pkg::*; #(
    parameter int DATA_W      = DATA_W_DEF,
    parameter int FRAC_W      = FRAC_W_DEF,
    parameter int SPIKE_SHIFT = 10,
    parameter int DT_SHIFT    = 10
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     step_i,
    input  logic        [DATA_W-1:0] spike_cnt_i,
    input  logic signed [DATA_W-1:0] length_i,
    input  logic signed [DATA_W-1:0] velocity_i,
    output logic                     force_valid_o,
    output logic signed [DATA_W-1:0] force_o,
    output logic signed [DATA_W-1:0] drive_o
);

    // stage 1 to stage 2
    logic                     act_valid;
    logic signed [DATA_W-1:0] act;

    // stage 2 to stage 3
    logic                     drive_valid;
    logic signed [DATA_W-1:0] drive;
    logic signed [DATA_W-1:0] len_s2;
    logic signed [DATA_W-1:0] vel_s2;

    // length and velocity wait one cycle, in step with act_valid
    logic signed [DATA_W-1:0] len_q;
    logic signed [DATA_W-1:0] vel_q;

    always_ff @(posedge clk) begin
        if (step_i) begin
            len_q <= length_i;
            vel_q <= velocity_i;
        end
    end

    spike_activation #(
        .DATA_W      (DATA_W),
        .FRAC_W      (FRAC_W),
        .SPIKE_SHIFT (SPIKE_SHIFT)
    ) u_act (
        .clk         (clk),
        .reset       (reset),
        .step_i      (step_i),
        .spike_cnt_i (spike_cnt_i),
        .act_valid_o (act_valid),
        .act_o       (act)
    );

    length_weight #(
        .DATA_W (DATA_W),
        .FRAC_W (FRAC_W)
    ) u_weight (
        .clk           (clk),
        .reset         (reset),
        .act_valid_i   (act_valid),
        .act_i         (act),
        .length_i      (len_q),
        .velocity_i    (vel_q),
        .drive_valid_o (drive_valid),
        .drive_o       (drive),
        .length_o      (len_s2),
        .velocity_o    (vel_s2)
    );

    tension_integrator #(
        .DATA_W   (DATA_W),
        .FRAC_W   (FRAC_W),
        .DT_SHIFT (DT_SHIFT)
    ) u_tension (
        .clk           (clk),
        .reset         (reset),
        .drive_valid_i (drive_valid),
        .drive_i       (drive),
        .length_i      (len_s2),
        .velocity_i    (vel_s2),
        .force_valid_o (force_valid_o),
        .force_o       (force_o)
    );

    assign drive_o = drive;

    // end to end, a step comes out as force three cycles later
    a_step_to_force: assert property (
        @(posedge clk) disable iff (reset)
        step_i |-> ##3 force_valid_o
    );

endmodule

`default_nettype wire

// ==== hw/spike_activation.sv ====
`timescale 1ns/1ps
`default_nettype none

module spike_activation import muscle_pkg::*; #(
    parameter int DATA_W      = DATA_W_DEF,
    parameter int FRAC_W      = FRAC_W_DEF,
    parameter int SPIKE_SHIFT = 10
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     step_i,
    input  logic        [DATA_W-1:0] spike_cnt_i,
    output logic                     act_valid_o,
    output logic signed [DATA_W-1:0] act_o
);

    // recurrence coefficients, rounded once
    localparam fx_wide_t C_B1 = fx_const(H_B1, FRAC_W);
    localparam fx_wide_t C_B2 = fx_const(H_B2, FRAC_W);
    localparam fx_wide_t C_A1 = fx_const(H_A1, FRAC_W);
    localparam fx_wide_t C_A2 = fx_const(H_A2, FRAC_W);

    // two-deep histories, spikes and h
    logic signed [DATA_W-1:0] spk_d1;
    logic signed [DATA_W-1:0] spk_d2;
    logic signed [DATA_W-1:0] h_d1;
    logic signed [DATA_W-1:0] h_d2;

    // scaled spike count for this step
    logic signed [DATA_W-1:0] spk_scaled;

    // partial terms of the difference equation
    fx_wide_t t_b1;
    fx_wide_t t_b2;
    fx_wide_t t_a1;
    fx_wide_t t_a2;
    fx_wide_t sum_b;
    fx_wide_t sum_a;
    logic signed [DATA_W-1:0] h_next;

    //////////////////////
    // input scaling
    // count times 2^SPIKE_SHIFT taken directly as a raw fixed point word
    // large counts clamp at the positive limit
    assign spk_scaled = DATA_W'(fx_sat(fx_wide_t'(spike_cnt_i) <<< SPIKE_SHIFT, DATA_W));

    //////////////////////
    // h(x) recurrence
    // h = b1*s1 + b2*s2 - (a1*h1 + a2*h2)
    // the new sample only enters through s1 on the next step
    always_comb begin
        t_b1   = fx_mul(C_B1, fx_wide_t'(spk_d1), DATA_W, FRAC_W);
        t_b2   = fx_mul(C_B2, fx_wide_t'(spk_d2), DATA_W, FRAC_W);
        t_a1   = fx_mul(C_A1, fx_wide_t'(h_d1), DATA_W, FRAC_W);
        t_a2   = fx_mul(C_A2, fx_wide_t'(h_d2), DATA_W, FRAC_W);
        sum_b  = fx_add(t_b1, t_b2, DATA_W);
        sum_a  = fx_add(t_a1, t_a2, DATA_W);
        h_next = DATA_W'(fx_add(sum_b, -sum_a, DATA_W));
    end

    // histories advance on a step only, so idle clocks leave the state alone
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            spk_d1 <= '0;
            spk_d2 <= '0;
            h_d1   <= '0;
            h_d2   <= '0;
        end else if (step_i) begin
            spk_d1 <= spk_scaled;
            spk_d2 <= spk_d1;
            h_d1   <= h_next;
            h_d2   <= h_d1;
        end
    end

    // stage output, held between steps
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            act_valid_o <= 1'b0;
            act_o       <= '0;
        end else begin
            act_valid_o <= step_i;
            if (step_i) begin
                act_o <= h_next;
            end
        end
    end

    // a nonzero count stays positive after scaling, no wrap to zero or below
    a_scaled_positive: assert property (
        @(posedge clk) disable iff (reset)
        (step_i && spike_cnt_i != '0) |-> (spk_scaled > 0)
    );

endmodule

`default_nettype wire

// ==== hw/tension_integrator.sv ====
`timescale 1ns/1ps
`default_nettype none

module tension_integrator import muscle_pkg::*; #(
    parameter int DATA_W   = DATA_W_DEF,
    parameter int FRAC_W   = FRAC_W_DEF,
    parameter int DT_SHIFT = 10
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     drive_valid_i,
    input  logic signed [DATA_W-1:0] drive_i,
    input  logic signed [DATA_W-1:0] length_i,
    input  logic signed [DATA_W-1:0] velocity_i,
    output logic                     force_valid_o,
    output logic signed [DATA_W-1:0] force_o
);

    // rate coefficients in the word's fraction
    localparam fx_wide_t C_LEN  = fx_const(K_LEN, FRAC_W);
    localparam fx_wide_t C_VEL  = fx_const(K_VEL, FRAC_W);
    localparam fx_wide_t C_TEN  = fx_const(K_TEN, FRAC_W);
    localparam fx_wide_t C_ACT  = fx_const(K_ACT, FRAC_W);
    localparam fx_wide_t C_REST = fx_const(L_REST, FRAC_W);

    // current tension, also the output word
    logic signed [DATA_W-1:0] tension;

    // rate terms
    fx_wide_t stretch;
    fx_wide_t t_len;
    fx_wide_t t_vel;
    fx_wide_t t_ten;
    fx_wide_t t_act;
    fx_wide_t part_lv;
    fx_wide_t part_lvt;
    fx_wide_t rate;
    fx_wide_t rate_dt;
    logic signed [DATA_W-1:0] tension_next;

    //////////////////////
    // tension rate
    // dT = 204*(x - 1) + 136*v - 4.22*T + 2.72*A
    // summed left to right, each step clamped
    always_comb begin
        stretch  = fx_add(fx_wide_t'(length_i), -C_REST, DATA_W);
        t_len    = fx_mul(C_LEN, stretch, DATA_W, FRAC_W);
        t_vel    = fx_mul(C_VEL, fx_wide_t'(velocity_i), DATA_W, FRAC_W);
        part_lv  = fx_add(t_len, t_vel, DATA_W);
        t_ten    = fx_mul(C_TEN, fx_wide_t'(tension), DATA_W, FRAC_W);
        part_lvt = fx_add(part_lv, -t_ten, DATA_W);
        t_act    = fx_mul(C_ACT, fx_wide_t'(drive_i), DATA_W, FRAC_W);
        rate     = fx_add(part_lvt, t_act, DATA_W);
    end

    //////////////////////
    // euler step
    // dt = 2^-DT_SHIFT, arithmetic shift floors negative rates
    always_comb begin
        rate_dt      = rate >>> DT_SHIFT;
        tension_next = DATA_W'(fx_add(fx_wide_t'(tension), rate_dt, DATA_W));
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tension       <= '0;
            force_valid_o <= 1'b0;
        end else begin
            force_valid_o <= drive_valid_i;
            // T only moves on a drive strobe
            if (drive_valid_i) begin
                tension <= tension_next;
            end
        end
    end

    // holds the post-update T between strobes
    assign force_o = tension;

    // T moves in the direction of the rate, so the update never wraps sign
    a_step_no_wrap: assert property (
        @(posedge clk) disable iff (reset)
        drive_valid_i |->
            ((rate_dt >= 0) ? (tension_next >= tension) : (tension_next <= tension))
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the muscle testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module muscle_tb \
    -f all.f \
    --Mdir obj_dir \
    -o muscle_sim

./obj_dir/muscle_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
